//--- files.f
hw/periph_bus_pkg.sv
hw/periph_pin_pkg.sv
hw/periph_decode.sv
hw/read_response.sv
hw/gpio_ctrl.sv
hw/byte_pwm.sv
hw/periph_top.sv
verification/periph_assertions.sv
verification/tb_periph_top.sv

//--- Bender.yml
package:
  name: periph_top

sources:
  - hw/periph_bus_pkg.sv
  - hw/periph_pin_pkg.sv
  - hw/periph_decode.sv
  - hw/read_response.sv
  - hw/gpio_ctrl.sv
  - hw/byte_pwm.sv
  - hw/periph_top.sv
  - target: simulation
    files:
      - verification/periph_assertions.sv
      - verification/tb_periph_top.sv

//--- verification/tb_periph_top.sv
`default_nettype none

module tb_periph_top
    import periph_bus_pkg::*, periph_pin_pkg::*;
();

    localparam int unsigned TEST_CYCLES = 30 * 4 + 2 * 256 + 16;  // Bus ops plus PWM windows
    localparam access_t     ACC_BYTE    = 2'b00;
    localparam access_t     ACC_WORD    = 2'b10;
    localparam func_sel_t   SEL_GPIO    = 5'b0_0001;
    localparam func_sel_t   SEL_PWM     = 5'b1_0101;  // Simple slot 5

    logic       clk;
    logic       rst_n;
    addr_t      addr;
    word_t      wdata;
    access_t    write_n;
    access_t    read_n;
    logic       read_complete;
    pins_t      ui_in;
    word_t      rdata;
    logic       ready;
    pins_t      uo_out;
    logic       audio;
    logic       audio_select;

    int unsigned errors = 0;
    pins_t       gpio_exp;       // Register shadow
    func_sel_t   func_exp [8];
    duty_t       duty_exp;
    audio_sel_t  audio_exp;

    periph_top periph_top_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_addr         (addr),
        .i_wdata        (wdata),
        .i_write_n      (write_n),
        .i_read_n       (read_n),
        .i_read_complete(read_complete),
        .i_ui_in        (ui_in),
        .o_rdata        (rdata),
        .o_ready        (ready),
        .o_uo_out       (uo_out),
        .o_audio        (audio),
        .o_audio_select (audio_select)
    );

    bind periph_top periph_assertions periph_assertions_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_read_n      (i_read_n),
        .i_hold        (hold_mask),
        .i_rdata       (o_rdata),
        .i_ready       (o_ready),
        .i_audio_select(o_audio_select)
    );

    always #5 clk = ~clk;

    function automatic addr_t user_addr(input int unsigned slot, input int unsigned ofs);
        return {1'b0, 4'(slot), 6'(ofs)};
    endfunction

    function automatic addr_t simple_addr(input int unsigned slot, input int unsigned ofs);
        return {1'b1, 2'b00, 4'(slot), 4'(ofs)};
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            errors++;
            $display("Mismatch at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            errors++;
            $display("Error at %0t: %s", $time, what);
        end
    endtask

    task automatic bus_write(input addr_t a, input word_t d, input access_t acc);
        @(posedge clk);
        #1;
        addr    = a;
        wdata   = d;
        write_n = acc;
        @(negedge clk);
        check_true(ready, $sformatf("No ready for write at address 0x%03h", a));
        @(posedge clk);
        #1;
        write_n = ACCESS_NONE;
    endtask

    task automatic bus_read(input addr_t a, output word_t d);
        int unsigned waited;
        @(posedge clk);
        #1;
        addr   = a;
        read_n = ACC_WORD;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!ready && waited < 8);
        check_true(ready, $sformatf("No ready for read at address 0x%03h", a));
        d = rdata;
        @(posedge clk);
        #1;
        read_n        = ACCESS_NONE;
        read_complete = 1'b1;  // Release the held data
        @(posedge clk);
        #1;
        read_complete = 1'b0;
    endtask

    task automatic read_check(input addr_t a, input word_t exp, input string name);
        word_t got;
        bus_read(a, got);
        check_value(name, got, exp);
    endtask

    // Counts PWM high cycles over one full counter period
    task automatic pwm_window();
        int unsigned audio_high;
        int unsigned pin_high [8];
        audio_high = 0;
        foreach (pin_high[p])
            pin_high[p] = 0;
        repeat (256) begin
            @(negedge clk);
            audio_high += audio;
            for (int p = 0; p < 8; p++) begin
                if (func_exp[p] == SEL_PWM) begin
                    pin_high[p] += uo_out[p];
                end else begin
                    check_value($sformatf("o_uo_out[%0d]", p), uo_out[p],
                                (func_exp[p] == SEL_GPIO) ? gpio_exp[p] : 1'b0);
                end
            end
        end
        check_value("o_audio high cycles", audio_high, duty_exp);
        for (int p = 0; p < 8; p++) begin
            if (func_exp[p] == SEL_PWM) begin
                check_value($sformatf("o_uo_out[%0d] high cycles", p), pin_high[p], duty_exp);
            end
        end
    endtask

    initial begin
        int unsigned cat;
        word_t       wdata_r;
        clk           = 1'b0;
        rst_n         = 1'b0;
        addr          = '0;
        wdata         = '0;
        write_n       = ACCESS_NONE;
        read_n        = ACCESS_NONE;
        read_complete = 1'b0;
        ui_in         = '0;
        void'($urandom(62));
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        ui_in = pins_t'($urandom);

        wdata_r  = $urandom | 32'h1;  // Nonzero for the hold test
        gpio_exp = wdata_r[7:0];
        bus_write(user_addr(1, 0), wdata_r, ACC_WORD);
        read_check(user_addr(1, 0), word_t'(gpio_exp), "GPIO out");
        read_check(user_addr(1, 4), word_t'(ui_in), "GPIO in");
        @(negedge clk);
        check_value("o_uo_out", uo_out, gpio_exp);

        for (int i = 0; i < 2; i++) begin
            wdata_r    = $urandom;
            wdata_r[2] = (i == 0);  // Select bit set, then cleared
            audio_exp  = wdata_r[2:0];
            bus_write(user_addr(1, 16), wdata_r, ACC_WORD);
            read_check(user_addr(1, 16), word_t'(audio_exp), "audio select");
            check_value("o_audio_select", audio_select, audio_exp[2]);
        end

        // Pins 0 to 2 cover GPIO, PWM and an empty slot
        for (int p = 0; p < 8; p++) begin
            cat = (p < 3) ? p : $urandom_range(2);
            case (cat)
                0: func_exp[p] = SEL_GPIO;
                1: func_exp[p] = SEL_PWM;
                default: begin
                    do
                        func_exp[p] = func_sel_t'($urandom);
                    while (func_exp[p] == SEL_GPIO || func_exp[p] == SEL_PWM);
                end
            endcase
            wdata_r      = $urandom;
            wdata_r[4:0] = func_exp[p];
            bus_write(user_addr(1, 32 + 4 * p), wdata_r, ACC_WORD);
            read_check(user_addr(1, 32 + 4 * p), word_t'(func_exp[p]),
                       $sformatf("function select %0d", p));
        end

        for (int i = 0; i < 2; i++) begin
            wdata_r  = $urandom;
            duty_exp = wdata_r[7:0];
            bus_write(simple_addr(5, 0), wdata_r, ACC_BYTE);
            read_check(simple_addr(5, 0), word_t'(duty_exp), "PWM duty");
            pwm_window();
        end
        read_check(simple_addr(5, 1), '0, "PWM offset 1");

        read_check(user_addr(3, 0), '0, "empty user slot");
        read_check(simple_addr(2, 0), '0, "empty simple slot");

        // Held data survives an address change and a still pending request
        @(posedge clk);
        #1;
        addr   = user_addr(1, 0);
        read_n = ACC_WORD;
        @(posedge clk);
        #1;
        addr = user_addr(3, 0);
        @(negedge clk);
        check_true(ready, "No ready for the held read");
        check_value("o_rdata", rdata, word_t'(gpio_exp));
        repeat (3) begin
            @(negedge clk);
            check_true(!ready, "Second read was not masked while data was held");
            check_value("o_rdata", rdata, word_t'(gpio_exp));
        end
        @(posedge clk);
        #1;
        read_n        = ACCESS_NONE;
        read_complete = 1'b1;
        @(posedge clk);
        #1;
        read_complete = 1'b0;
        read_check(user_addr(3, 0), '0, "empty user slot after hold");

        $display("Errors: %0d testbench, %0d assertion", errors,
                 periph_top_i.periph_assertions_i.fail_count);
        if (errors == 0 && periph_top_i.periph_assertions_i.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(TEST_CYCLES * 10 + 1000);
        $display("Timeout: the tests did not finish within %0d cycles", TEST_CYCLES);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/periph_assertions.sv
`default_nettype none

module periph_assertions
    import periph_bus_pkg::*;
(
    input logic    clk,
    input logic    rst_n,
    input access_t i_read_n,
    input logic    i_hold,
    input word_t   i_rdata,
    input logic    i_ready,
    input logic    i_audio_select
);

    int unsigned fail_count = 0;

    // A fresh read request gets ready on the next cycle
    ready_after_read: assert property (@(posedge clk) disable iff (!rst_n)
        (i_read_n != ACCESS_NONE && !i_hold) |=> i_ready)
    else begin
        fail_count++;
        $error("o_ready did not rise one cycle after a read request");
    end

    // Captured data cannot move while the hold is set
    rdata_held: assert property (@(posedge clk) disable iff (!rst_n)
        i_hold |=> $stable(i_rdata))
    else begin
        fail_count++;
        $error("o_rdata changed while the read data was held");
    end

    reset_state: assert property (@(posedge clk)
        $rose(rst_n) |-> (!i_audio_select && !i_ready))
    else begin
        fail_count++;
        $error("o_audio_select or o_ready was high after reset");
    end

endmodule

`default_nettype wire

//--- hw/periph_top.sv
`default_nettype none

// Peripheral wrapper with GPIO in user slot 1 and PWM in simple slot 5
module periph_top
    import periph_bus_pkg::*, periph_pin_pkg::*;
#(
    parameter int unsigned NUM_PINS  = 8,
    parameter int unsigned GPIO_SLOT = 1,
    parameter int unsigned PWM_SLOT  = 5
) (
    input  logic    clk,
    input  logic    rst_n,
    input  addr_t   i_addr,
    input  word_t   i_wdata,
    input  access_t i_write_n,
    input  access_t i_read_n,
    input  logic    i_read_complete,
    input  pins_t   i_ui_in,
    output word_t   o_rdata,
    output logic    o_ready,
    output pins_t   o_uo_out,
    output logic    o_audio,
    output logic    o_audio_select
);

    logic  gpio_we;
    logic  pwm_we;
    word_t gpio_rdata;
    byte_t pwm_rdata;
    word_t periph_rdata;
    logic  periph_ready;
    logic  hold_mask;
    pins_t pwm_pins;

    periph_decode #(
        .GPIO_SLOT(GPIO_SLOT),
        .PWM_SLOT (PWM_SLOT)
    ) periph_decode_i (
        .i_addr        (i_addr),
        .i_write_n     (i_write_n),
        .i_read_n      (i_read_n),
        .i_hold_mask   (hold_mask),
        .i_gpio_rdata  (gpio_rdata),
        .i_pwm_rdata   (pwm_rdata),
        .o_gpio_we     (gpio_we),
        .o_pwm_we      (pwm_we),
        .o_periph_rdata(periph_rdata),
        .o_periph_ready(periph_ready)
    );

    read_response read_response_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_read_n       (i_read_n),
        .i_write_n      (i_write_n),
        .i_read_complete(i_read_complete),
        .i_periph_rdata (periph_rdata),
        .i_periph_ready (periph_ready),
        .o_rdata        (o_rdata),
        .o_ready        (o_ready),
        .o_hold_mask    (hold_mask)
    );

    gpio_ctrl #(
        .NUM_PINS(NUM_PINS),
        .PWM_SLOT(PWM_SLOT)
    ) gpio_ctrl_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_we          (gpio_we),
        .i_offset      (i_addr[$bits(user_offset_t)-1:0]),
        .i_wdata       (i_wdata),
        .i_ui_in       (i_ui_in),
        .i_pwm_pins    (pwm_pins),
        .o_rdata       (gpio_rdata),
        .o_uo_out      (o_uo_out),
        .o_audio_select(o_audio_select)
    );

    byte_pwm byte_pwm_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_we    (pwm_we),
        .i_offset(i_addr[$bits(byte_offset_t)-1:0]),
        .i_wdata (i_wdata[$bits(byte_t)-1:0]),  // Byte interface uses the low lane
        .o_rdata (pwm_rdata),
        .o_pins  (pwm_pins),
        .o_audio (o_audio)
    );

endmodule

`default_nettype wire

//--- hw/byte_pwm.sv
`default_nettype none

module byte_pwm
    import periph_bus_pkg::*, periph_pin_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         i_we,
    input  byte_offset_t i_offset,
    input  byte_t        i_wdata,
    output byte_t        o_rdata,
    output pins_t        o_pins,
    output logic         o_audio
);

    localparam byte_offset_t DUTY_OFS = 4'd0;

    duty_t duty;
    duty_t count;
    logic  pwm_high;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            duty <= '0;
        end else if (i_we && i_offset == DUTY_OFS) begin
            duty <= i_wdata;
        end
    end

    // Free running, wraps every 256 cycles
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // High for duty cycles out of 256
    assign pwm_high = count < duty;

    assign o_rdata = (i_offset == DUTY_OFS) ? duty : '0;
    assign o_pins  = {$bits(pins_t){pwm_high}};
    assign o_audio = pwm_high;

endmodule

`default_nettype wire

//--- hw/gpio_ctrl.sv
`default_nettype none

module gpio_ctrl
    import periph_bus_pkg::*, periph_pin_pkg::*;
#(
    parameter int unsigned NUM_PINS = 8,
    parameter int unsigned PWM_SLOT = 5
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         i_we,
    input  user_offset_t i_offset,
    input  word_t        i_wdata,
    input  pins_t        i_ui_in,
    input  pins_t        i_pwm_pins,
    output word_t        o_rdata,
    output pins_t        o_uo_out,
    output logic         o_audio_select
);

    localparam func_sel_t FUNC_PWM = {1'b1, slot_t'(PWM_SLOT)};

    pins_t      gpio_out;
    audio_sel_t audio_sel;
    func_sel_t  func_sel [NUM_PINS];

    // Register offset of a pin's function select
    function automatic user_offset_t func_sel_ofs(input int unsigned pin);
        return user_offset_t'(FUNC_SEL_BASE + 4 * pin);
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out  <= '0;
            audio_sel <= '0;
        end else if (i_we) begin
            if (i_offset == GPIO_OUT_OFS) begin
                gpio_out <= i_wdata[$bits(pins_t)-1:0];
            end
            if (i_offset == AUDIO_SEL_OFS) begin
                audio_sel <= i_wdata[$bits(audio_sel_t)-1:0];
            end
        end
    end

    for (genvar p = 0; p < NUM_PINS; p++) begin : g_func_sel
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                func_sel[p] <= FUNC_GPIO;  // All pins start as GPIO
            end else if (i_we && i_offset == func_sel_ofs(p)) begin
                func_sel[p] <= i_wdata[$bits(func_sel_t)-1:0];
            end
        end
    end

    // Read-back
    always_comb begin
        o_rdata = '0;
        if (i_offset == GPIO_OUT_OFS) begin
            o_rdata = word_t'(gpio_out);
        end else if (i_offset == GPIO_IN_OFS) begin
            o_rdata = word_t'(i_ui_in);
        end else if (i_offset == AUDIO_SEL_OFS) begin
            o_rdata = word_t'(audio_sel);
        end
        for (int unsigned p = 0; p < NUM_PINS; p++) begin
            if (i_offset == func_sel_ofs(p)) begin
                o_rdata = word_t'(func_sel[p]);
            end
        end
    end

    // Output pin multiplexer
    always_comb begin
        o_uo_out = '0;  // Unpopulated sources drive low
        for (int unsigned p = 0; p < NUM_PINS; p++) begin
            if (func_sel[p] == FUNC_GPIO) begin
                o_uo_out[p] = gpio_out[p];
            end else if (func_sel[p] == FUNC_PWM) begin
                o_uo_out[p] = i_pwm_pins[p];
            end
        end
    end

    assign o_audio_select = audio_sel[2];

endmodule

`default_nettype wire

//--- hw/read_response.sv
`default_nettype none

module read_response
    import periph_bus_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  access_t i_read_n,
    input  access_t i_write_n,
    input  logic    i_read_complete,
    input  word_t   i_periph_rdata,
    input  logic    i_periph_ready,
    output word_t   o_rdata,
    output logic    o_ready,
    output logic    o_hold_mask
);

    logic  hold;
    logic  ready_r;
    logic  capture;
    word_t rdata_r;

    assign capture = (i_read_n != ACCESS_NONE) && i_periph_ready && !hold;

    // Data stays put until the core signals completion
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_r <= 1'b0;
        end else begin
            if (capture) begin
                hold <= 1'b1;
            end else if (i_read_complete) begin
                hold <= 1'b0;
            end
            ready_r <= capture;  // One cycle after the request
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            rdata_r <= i_periph_rdata;
        end
    end

    assign o_rdata     = rdata_r;
    assign o_ready     = ready_r || (i_write_n != ACCESS_NONE);  // Writes finish at once
    assign o_hold_mask = hold;

endmodule

`default_nettype wire

//--- hw/periph_decode.sv
`default_nettype none

module periph_decode
    import periph_bus_pkg::*, periph_pin_pkg::*;
#(
    parameter int unsigned GPIO_SLOT = 1,
    parameter int unsigned PWM_SLOT  = 5
) (
    input  addr_t   i_addr,
    input  access_t i_write_n,
    input  access_t i_read_n,
    input  logic    i_hold_mask,
    input  word_t   i_gpio_rdata,
    input  byte_t   i_pwm_rdata,
    output logic    o_gpio_we,
    output logic    o_pwm_we,
    output word_t   o_periph_rdata,
    output logic    o_periph_ready
);

    localparam int unsigned NUM_SLOTS = 2 ** $bits(slot_t);

    logic                 simple_space;
    slot_t                user_slot;
    slot_t                simple_slot;
    logic [NUM_SLOTS-1:0] user_sel;    // One-hot
    logic [NUM_SLOTS-1:0] simple_sel;  // One-hot
    logic                 write_req;
    access_t              read_masked;

    assign simple_space = i_addr[SIMPLE_SEL_BIT];
    assign user_slot    = i_addr[USER_SLOT_LSB +: $bits(slot_t)];
    assign simple_slot  = i_addr[SIMPLE_SLOT_LSB +: $bits(slot_t)];

    always_comb begin
        user_sel   = '0;
        simple_sel = '0;
        if (simple_space) begin
            simple_sel[simple_slot] = 1'b1;
        end else begin
            user_sel[user_slot] = 1'b1;
        end
    end

    // Write strobes only for populated slots
    assign write_req = i_write_n != ACCESS_NONE;
    assign o_gpio_we = write_req && user_sel[GPIO_SLOT];
    assign o_pwm_we  = write_req && simple_sel[PWM_SLOT];

    // Empty slots read as zero
    always_comb begin
        o_periph_rdata = '0;
        if (simple_sel[PWM_SLOT]) begin
            o_periph_rdata = word_t'(i_pwm_rdata);  // Byte zero-extended
        end else if (user_sel[GPIO_SLOT]) begin
            o_periph_rdata = i_gpio_rdata;
        end
    end

    // All slots answer at once, held data blocks a second read
    assign read_masked    = i_read_n | {$bits(access_t){i_hold_mask}};
    assign o_periph_ready = read_masked != ACCESS_NONE;

endmodule

`default_nettype wire

//--- hw/periph_pin_pkg.sv
`default_nettype none

// Pin routing and peripheral payload types
package periph_pin_pkg;

    typedef logic [3:0] slot_t;
    typedef logic [4:0] func_sel_t;  // Bit 4 picks simple slots, bits 3:0 the slot
    typedef logic [7:0] pins_t;
    typedef logic [7:0] byte_t;
    typedef logic [7:0] duty_t;
    typedef logic [2:0] audio_sel_t;

    // User slot 1 is the GPIO block
    localparam func_sel_t FUNC_GPIO = 5'd1;

endpackage

`default_nettype wire

//--- hw/periph_bus_pkg.sv
`default_nettype none

// Core data bus as seen by the peripheral wrapper
package periph_bus_pkg;

    typedef logic [10:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [1:0]  access_t;      // 00 byte, 01 half, 10 word, 11 idle
    typedef logic [5:0]  user_offset_t; // Register offset in a 64-byte slot
    typedef logic [3:0]  byte_offset_t; // Register offset in a 16-byte slot

    localparam access_t ACCESS_NONE = 2'b11;

    // Address fields
    localparam int unsigned SIMPLE_SEL_BIT  = 10; // High half holds the simple slots
    localparam int unsigned USER_SLOT_LSB   = 6;  // User slot in bits 9:6
    localparam int unsigned SIMPLE_SLOT_LSB = 4;  // Simple slot in bits 7:4

    // GPIO register map
    localparam user_offset_t GPIO_OUT_OFS  = 6'd0;
    localparam user_offset_t GPIO_IN_OFS   = 6'd4;
    localparam user_offset_t AUDIO_SEL_OFS = 6'd16;
    localparam user_offset_t FUNC_SEL_BASE = 6'd32; // One word per pin from here

endpackage

`default_nettype wire
